//--- files.f
src/conv_pkg.sv
src/conv_user_pkg.sv
src/step_buffer.sv
src/mul_pipe.sv
src/lane_accumulator.sv
src/conv_unit.sv
verification/conv_unit_asserts.sv
verification/conv_unit_tb.sv

//--- Bender.yml
package:
  name: conv_unit

sources:
  - src/conv_pkg.sv
  - src/conv_user_pkg.sv
  - src/step_buffer.sv
  - src/mul_pipe.sv
  - src/lane_accumulator.sv
  - src/conv_unit.sv
  - target: test
    files:
      - verification/conv_unit_asserts.sv
      - verification/conv_unit_tb.sv

//--- verification/conv_unit_tb.sv
/*
 * Testbench for the column convolution unit
 * Runs a table of block tests with random pixels and weights, models
 * the bias and the lane chaining, and checks each lane result and latency.
 */
module conv_unit_tb
    import conv_pkg::*;
    import conv_user_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 7;
    localparam int MAX_LEN    = 8;

    typedef struct {
        int    blocks;
        int    len;
        logic  is_1x1;
        logic  is_relu;
        logic  gaps;
        string name;
    } test_row_t;

    // Blocks, beats per block, 1x1, ReLU, aclken gaps, name
    test_row_t tests [NUM_TESTS] = '{
        '{1, 4, 1'b0, 1'b0, 1'b0, "single_block"},
        '{6, 3, 1'b0, 1'b0, 1'b0, "chain"},
        '{6, 3, 1'b0, 1'b1, 1'b0, "relu_chain"},
        '{4, 2, 1'b1, 1'b0, 1'b0, "one_by_one"},
        '{5, 1, 1'b0, 1'b0, 1'b0, "short_blocks"},
        '{8, 3, 1'b0, 1'b1, 1'b1, "enable_gaps"},
        '{4, 2, 1'b1, 1'b1, 1'b1, "one_by_one_gaps"}
    };

    logic     aclk;
    logic     rst_n;
    logic     aclken;
    logic     s_valid;
    logic     s_last;
    data_t    s_pixel;
    weights_t s_weights;
    data_t    s_bias;
    user_t    s_user;
    logic     m_valid [KERNEL_W];
    acc_t     m_data  [KERNEL_W];
    user_t    m_user  [KERNEL_W];

    logic [31:0] lfsr = 32'h68ff_75ed;
    int exp_q [KERNEL_W][$];
    user_t user_q [KERNEL_W][$];
    int due_q [KERNEL_W][$];
    int raw_prev [KERNEL_W];
    int edge_cnt;
    int check_cnt;
    int fail_cnt;

    conv_unit DUT (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int rand_signed(int n);
        logic [31:0] r;
        r = rand_bits(n);
        return $signed(r << (32 - n)) >>> (32 - n);
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < KERNEL_W; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    function automatic int error_count();
        return fail_cnt + DUT.u_asserts.err_cnt;
    endfunction

    task automatic idle_cycle(logic gaps);
        @(posedge aclk);
        aclken  <= gaps ? (rand_bits(2) != 0) : 1'b1;
        s_valid <= 1'b0;
        s_last  <= 1'b0;
        s_user  <= '0;
    endtask

    task automatic send_block(test_row_t row);
        int    pix [MAX_LEN];
        int    wt  [MAX_LEN][KERNEL_W];
        int    raw [KERNEL_W];
        int    bias;
        user_t blk_user;
        logic  en;
        bias = rand_signed(12);
        for (int b = 0; b < row.len; b++) begin
            pix[b] = rand_signed(8);
            for (int k = 0; k < KERNEL_W; k++) begin
                wt[b][k] = rand_signed(8);
            end
        end
        // Lane 0 starts from the bias and lane k from lane k-1 of the block before
        for (int k = 0; k < KERNEL_W; k++) begin
            raw[k] = (k == 0) ? bias : (row.is_1x1 ? 0 : raw_prev[k-1]);
            for (int b = 0; b < row.len; b++) begin
                raw[k] += pix[b] * wt[b][k];
            end
        end
        // Flags of the block as its first beat carries them
        blk_user = '{is_1x1: row.is_1x1, is_relu: row.is_relu, cin_first: 1'b1};
        for (int k = 0; k < KERNEL_W; k++) begin
            raw_prev[k] = raw[k];
            exp_q[k].push_back((row.is_relu && raw[k] < 0) ? 0 : raw[k]);
            user_q[k].push_back(blk_user);
        end
        for (int b = 0; b < row.len; b++) begin
            // Beat is offered again until aclken lets it in
            do begin
                @(posedge aclk);
                en = row.gaps ? (rand_bits(2) != 0) : 1'b1;
                aclken  <= en;
                s_valid <= 1'b1;
                s_last  <= (b == row.len - 1);
                s_pixel <= data_t'(pix[b]);
                s_bias  <= data_t'(bias);
                s_user  <= '{is_1x1: row.is_1x1, is_relu: row.is_relu, cin_first: (b == 0)};
                for (int k = 0; k < KERNEL_W; k++) begin
                    s_weights[k] <= data_t'(wt[b][k]);
                end
            end while (!en);
        end
    endtask

    task automatic run_test(test_row_t row);
        int errs_before;
        errs_before = error_count();
        // Empty delay lines before any 1x1 block
        repeat (KERNEL_W + 1) idle_cycle(1'b0);
        for (int j = 0; j < row.blocks; j++) begin
            send_block(row);
        end
        while (pending() != 0) begin
            idle_cycle(row.gaps);
        end
        if (error_count() == errs_before) begin
            $display("test %-16s ok", row.name);
        end else begin
            $display("test %-16s %0d errors", row.name, error_count() - errs_before);
        end
    endtask

    // Counts enabled edges so latency holds with or without gaps
    always @(posedge aclk) begin : monitor
        int    expected;
        int    due;
        user_t exp_user;
        if (rst_n && aclken) begin
            edge_cnt++;
            if (s_valid && s_last) begin
                for (int k = 0; k < KERNEL_W; k++) begin
                    due_q[k].push_back(edge_cnt + (s_user.is_1x1 ? 0 : k) + MUL_DELAY + 1);
                end
            end
            for (int k = 0; k < KERNEL_W; k++) begin
                if (m_valid[k]) begin
                    check_cnt++;
                    assert (exp_q[k].size() > 0 && due_q[k].size() > 0) else begin
                        $display("Lane %0d gave a result at %0t with no block due", k, $time);
                        fail_cnt++;
                    end
                    if (exp_q[k].size() > 0 && due_q[k].size() > 0) begin
                        expected = exp_q[k].pop_front();
                        exp_user = user_q[k].pop_front();
                        due      = due_q[k].pop_front();
                        assert (m_data[k] == expected) else begin
                            $display("FAILED t=%0t m_data[%0d] got %0d expected %0d",
                                     $time, k, m_data[k], expected);
                            fail_cnt++;
                        end
                        assert (m_user[k] == exp_user) else begin
                            $display("FAILED t=%0t m_user[%0d] got %b expected %b",
                                     $time, k, m_user[k], exp_user);
                            fail_cnt++;
                        end
                        assert (edge_cnt == due) else begin
                            $display("FAILED t=%0t m_valid[%0d] edge got %0d expected %0d",
                                     $time, k, edge_cnt, due);
                            fail_cnt++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        aclken    = 1'b1;
        s_valid   = 1'b0;
        s_last    = 1'b0;
        s_pixel   = '0;
        s_weights = '0;
        s_bias    = '0;
        s_user    = '0;
        repeat (16) @(posedge aclk);
        rst_n <= 1'b1;
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, error_count());
        if (error_count() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Budget from the table where gap tests count double
    initial begin : watchdog
        int cycles;
        cycles = 16;
        foreach (tests[i]) begin
            cycles += tests[i].blocks * tests[i].len * (tests[i].gaps ? 2 : 1) + 50;
        end
        #(cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, lane results still missing", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verification/conv_unit_asserts.sv
/*
 * Output checks for the column convolution unit
 * Bound to the top level to cover reset and clock enable behaviour.
 */
module conv_unit_asserts
    import conv_pkg::*;
    import conv_user_pkg::*;
(
    input logic  aclk,
    input logic  rst_n,
    input logic  aclken,
    input logic  m_valid [KERNEL_W],
    input user_t m_user  [KERNEL_W]
);

    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;

    for (genvar k = 0; k < KERNEL_W; k++) begin : g_lane
        // Valid is cleared by every reset edge
        valid_in_reset: assert property (@(posedge aclk) !rst_n |=> !m_valid[k])
            else begin
                $error("m_valid[%0d] high during reset", k);
                err_cnt++;
            end

        // Stalled pipeline keeps its flags
        user_hold: assert property (@(posedge aclk) disable iff (!rst_n)
            !aclken |=> $stable(m_user[k]))
            else begin
                $error("m_user[%0d] changed while aclken was low", k);
                err_cnt++;
            end

        // Results only start on enabled edges
        valid_rise: assert property (@(posedge aclk) disable iff (!rst_n)
            !aclken |=> !$rose(m_valid[k]))
            else begin
                $error("m_valid[%0d] rose while aclken was low", k);
                err_cnt++;
            end
    end

endmodule

bind conv_unit conv_unit_asserts u_asserts (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .aclken  (aclken),
    .m_valid (m_valid),
    .m_user  (m_user)
);

//--- src/conv_unit.sv
/*
 * Column convolution unit
 * Staggers the pixel stream over the kernel columns, multiplies each
 * lane by its weight and accumulates blocks, chaining lane results.
 */
module conv_unit
    import conv_pkg::*;
    import conv_user_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     aclken,
    input  logic     s_valid,
    input  logic     s_last,
    input  data_t    s_pixel,
    input  weights_t s_weights,
    input  data_t    s_bias,
    input  user_t    s_user,
    output logic     m_valid [KERNEL_W],
    output acc_t     m_data  [KERNEL_W],
    output user_t    m_user  [KERNEL_W]
);

    beat_t    in_beat;
    beat_t    buf_beats [KERNEL_W];
    weights_t buf_weights;

    logic  mul_valid   [KERNEL_W];
    acc_t  mul_product [KERNEL_W];
    logic  mul_last    [KERNEL_W];
    user_t mul_user    [KERNEL_W];

    logic  lane_done   [KERNEL_W];
    acc_t  lane_result [KERNEL_W];

    data_t bias_q [MUL_DELAY];

    assign in_beat = '{valid: s_valid, pixel: s_pixel, last: s_last, user: s_user};

    step_buffer u_step_buffer (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .s_beat    (in_beat),
        .s_weights (s_weights),
        .m_beats   (buf_beats),
        .m_weights (buf_weights)
    );

    // Bias follows lane 0 through the multiplier latency
    always_ff @(posedge aclk) begin
        if (aclken) begin
            bias_q[0] <= s_bias;
            for (int i = 1; i < MUL_DELAY; i++) begin
                bias_q[i] <= bias_q[i-1];
            end
        end
    end

    for (genvar k = 0; k < KERNEL_W; k++) begin : g_lane
        acc_t lane_init;
        logic prev_done;
        acc_t prev_result;

        // Lane 0 starts from the bias, the others from their neighbour
        if (k == 0) begin : g_head
            assign lane_init   = acc_t'(bias_q[MUL_DELAY-1]);
            assign prev_done   = 1'b0;
            assign prev_result = '0;
        end else begin : g_link
            assign lane_init   = '0;
            assign prev_done   = lane_done[k-1];
            assign prev_result = lane_result[k-1];
        end

        mul_pipe u_mul (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .aclken    (aclken),
            .s_beat    (buf_beats[k]),
            .s_weight  (buf_weights[k]),
            .m_valid   (mul_valid[k]),
            .m_product (mul_product[k]),
            .m_last    (mul_last[k]),
            .m_user    (mul_user[k])
        );

        lane_accumulator u_acc (
            .aclk         (aclk),
            .rst_n        (rst_n),
            .aclken       (aclken),
            .s_valid      (mul_valid[k]),
            .s_product    (mul_product[k]),
            .s_last       (mul_last[k]),
            .s_user       (mul_user[k]),
            .init_value   (lane_init),
            .chain_done   (prev_done),
            .chain_result (prev_result),
            .m_valid      (m_valid[k]),
            .m_data       (m_data[k]),
            .m_user       (m_user[k]),
            .done         (lane_done[k]),
            .result       (lane_result[k])
        );
    end

endmodule

//--- src/lane_accumulator.sv
/*
 * Lane accumulator
 * Sums the products of one block, starting from the bias or from the
 * result the previous lane finished. Applies ReLU on the output only.
 */
module lane_accumulator
    import conv_pkg::*;
    import conv_user_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  aclken,
    input  logic  s_valid,
    input  acc_t  s_product,
    input  logic  s_last,
    input  user_t s_user,
    input  acc_t  init_value,
    input  logic  chain_done,
    input  acc_t  chain_result,
    output logic  m_valid,
    output acc_t  m_data,
    output user_t m_user,
    output logic  done,
    output acc_t  result
);

    acc_t  held_q;
    acc_t  sum_q;
    acc_t  init_sum;
    acc_t  base;
    acc_t  sum_next;
    user_t blk_user_q;
    user_t blk_user;

    // Flags belong to the block, so hold those of its first beat
    assign blk_user = s_user.cin_first ? s_user : blk_user_q;

    // Chained part of the init is dropped for 1x1 blocks
    assign init_sum = init_value + (s_user.is_1x1 ? acc_t'(0) : held_q);
    assign base     = s_user.cin_first ? init_sum : sum_q;
    assign sum_next = base + s_product;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            held_q  <= '0;
            m_valid <= 1'b0;
        end else if (aclken) begin
            if (chain_done) begin
                held_q <= chain_result;
            end
            m_valid <= s_valid && s_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && s_valid) begin
            sum_q      <= sum_next;
            blk_user_q <= blk_user;
            if (s_last) begin
                result <= sum_next;
                m_user <= blk_user;
                // Negative sums clamp to zero, the chain keeps the raw value
                m_data <= (blk_user.is_relu && sum_next < 0) ? acc_t'(0) : sum_next;
            end
        end
    end

    // Next lane samples this on its own enabled edge
    assign done = m_valid;

endmodule

//--- src/mul_pipe.sv
/*
 * Multiplier pipe
 * Signed pixel by weight product, carried with its valid, last and
 * flags through a fixed number of register stages.
 */
module mul_pipe
    import conv_pkg::*;
    import conv_user_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  aclken,
    input  beat_t s_beat,
    input  data_t s_weight,
    output logic  m_valid,
    output acc_t  m_product,
    output logic  m_last,
    output user_t m_user
);

    typedef struct packed {
        logic  valid;
        acc_t  product;
        logic  last;
        user_t user;
    } stage_t;

    data_t  pixel;
    stage_t stage_in;
    stage_t pipe_q [MUL_DELAY];

    assign pixel = s_beat.pixel;

    // Full-width signed product, no rounding
    assign stage_in = '{valid:   s_beat.valid,
                        product: acc_t'(pixel) * acc_t'(s_weight),
                        last:    s_beat.last,
                        user:    s_beat.user};

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < MUL_DELAY; i++) begin
                pipe_q[i].valid <= 1'b0;
            end
        end else if (aclken) begin
            pipe_q[0] <= stage_in;
            for (int i = 1; i < MUL_DELAY; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign m_valid   = pipe_q[MUL_DELAY-1].valid;
    assign m_product = pipe_q[MUL_DELAY-1].product;
    assign m_last    = pipe_q[MUL_DELAY-1].last;
    assign m_user    = pipe_q[MUL_DELAY-1].user;

endmodule

//--- src/step_buffer.sv
/*
 * Step buffer
 * Delays lane k of the pixel stream and its weight by k cycles so the
 * kernel columns are staggered. A 1x1 block skips the delay lines.
 */
module step_buffer
    import conv_pkg::*;
    import conv_user_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     aclken,
    input  beat_t    s_beat,
    input  weights_t s_weights,
    output beat_t    m_beats [KERNEL_W],
    output weights_t m_weights
);

    logic  mode_1x1_q;
    logic  bypass;
    beat_t chain_in;

    // Mode is decided by the first beat and kept for the block
    assign bypass = (s_beat.valid && s_beat.user.cin_first) ? s_beat.user.is_1x1
                                                           : mode_1x1_q;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            mode_1x1_q <= 1'b0;
        end else if (aclken && s_beat.valid && s_beat.user.cin_first) begin
            mode_1x1_q <= s_beat.user.is_1x1;
        end
    end

    // Bypassed beats leave a bubble in the chains
    always_comb begin
        chain_in = s_beat;
        if (bypass) begin
            chain_in.valid = 1'b0;
        end
    end

    // Lane 0 has no delay
    assign m_beats[0]   = s_beat;
    assign m_weights[0] = s_weights[0];

    for (genvar k = 1; k < KERNEL_W; k++) begin : g_lane
        beat_t beat_sr   [k];
        data_t weight_sr [k];

        always_ff @(posedge aclk) begin
            if (!rst_n) begin
                for (int i = 0; i < k; i++) begin
                    beat_sr[i].valid <= 1'b0;
                end
            end else if (aclken) begin
                beat_sr[0]   <= chain_in;
                weight_sr[0] <= s_weights[k];
                for (int i = 1; i < k; i++) begin
                    beat_sr[i]   <= beat_sr[i-1];
                    weight_sr[i] <= weight_sr[i-1];
                end
            end
        end

        assign m_beats[k]   = bypass ? s_beat : beat_sr[k-1];
        assign m_weights[k] = bypass ? s_weights[k] : weight_sr[k-1];
    end

endmodule

//--- src/conv_user_pkg.sv
/*
 * Stream sideband package
 * Block flags and the beat record that travels down each lane.
 */
package conv_user_pkg;

    import conv_pkg::*;

    // Flags of a block, sampled on its first beat
    typedef struct packed {
        logic is_1x1;
        logic is_relu;
        logic cin_first;
    } user_t;

    // One pixel beat with its control bits
    typedef struct packed {
        logic  valid;
        data_t pixel;
        logic  last;
        user_t user;
    } beat_t;

endpackage

//--- src/conv_pkg.sv
/*
 * Convolution datapath package
 * Numeric sizes, pipeline depth and the fixed-point word types
 * shared by the column convolution unit and its lanes.
 */
package conv_pkg;

    // Kernel columns, one lane per column
    localparam int KERNEL_W = 3;

    // Pixel, weight and bias width
    localparam int DATA_W = 16;

    // Product and running sum width
    localparam int ACC_W = 32;

    // Register stages in the multiplier pipe
    localparam int MUL_DELAY = 3;

    // Signed fixed-point input word
    typedef logic signed [DATA_W-1:0] data_t;

    // Signed product and accumulator word
    typedef logic signed [ACC_W-1:0] acc_t;

    // One weight per kernel column, lane 0 in the low slot
    typedef data_t [KERNEL_W-1:0] weights_t;

endpackage
